// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# Exit status is zero only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
TOP=ntm_content_based_addressing_tb

# Elaborate, compile and link the simulation binary
if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -Mdir "$OBJ" -o "$TOP" -f sources.f; then
  echo "Verilator build failed"
  exit 1
fi

# Let assertion errors reach the end of the run
"./$OBJ/$TOP" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Verification passed" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// ==== sim/ntm_content_based_addressing_chk.sv ====
//////////////////////////////
// Protocol assertions on the top level, bound into the DUT.
// Weights only while busy, ready right after a weight,
// never more weights than rows in one run.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ntm_content_based_addressing_chk #(
  parameter int I_MAX = 8
) (
  input wire                       CLK,
  input wire                       RST,
  input wire                       start,
  input wire                       busy,
  input wire                       c_out_enable,
  input wire                       ready,
  input wire [$clog2(I_MAX+1)-1:0] size_i_r
);

  // Count of failed assertions
  int unsigned fail_count = 0;

  // Weights seen since the last accepted start
  logic [$clog2(I_MAX+1)-1:0] strobe_cnt;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST)
      strobe_cnt <= '0;
    else if (start && !busy)
      strobe_cnt <= '0;
    else if (c_out_enable)
      strobe_cnt <= strobe_cnt + 1'b1;
  end

  a_idle_quiet: assert property (@(posedge CLK) disable iff (RST) c_out_enable |-> busy)
    else begin
      fail_count = fail_count + 1;
      $error("c_out_enable strobed while idle");
    end

  a_ready_after_weight: assert property (@(posedge CLK) disable iff (RST)
    ready |-> $past(c_out_enable))
    else begin
      fail_count = fail_count + 1;
      $error("ready without a weight in the cycle before");
    end

  // One strobe per row at most
  a_weight_count: assert property (@(posedge CLK) disable iff (RST)
    c_out_enable |-> strobe_cnt < size_i_r)
    else begin
      fail_count = fail_count + 1;
      $error("more weights than rows in one run");
    end

endmodule

`default_nettype wire

// ==== sim/ntm_content_based_addressing_tb.sv ====
//////////////////////////////
// Directed testbench for the content-based addressing unit.
// Streams key and rows, builds expected weights with an
// integer reference model, compares every c_out strobe.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ntm_content_based_addressing_tb;

  import ntm_pkg::*;

  localparam int I_MAX      = 8;
  localparam int J_MAX      = 16;
  localparam int WAIT_LIMIT = 3000;

  logic                       CLK;
  logic                       RST;
  logic                       start;
  logic [$clog2(I_MAX+1)-1:0] size_i;
  logic [$clog2(J_MAX+1)-1:0] size_j;
  beta_t                      beta;
  elem_t                      k_in;
  logic                       k_in_enable;
  elem_t                      m_in;
  logic                       m_in_enable;
  prob_t                      c_out;
  logic                       c_out_enable;
  logic                       ready;

  // Stimulus and expected weights of the current run
  int          key_v [J_MAX];
  int          mem_v [I_MAX][J_MAX];
  logic [63:0] exp_w [I_MAX];
  int          seed;

  ntm_content_based_addressing #(.I_MAX(I_MAX), .J_MAX(J_MAX)) i_dut (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .size_i       (size_i),
    .size_j       (size_j),
    .beta         (beta),
    .k_in         (k_in),
    .k_in_enable  (k_in_enable),
    .m_in         (m_in),
    .m_in_enable  (m_in_enable),
    .c_out        (c_out),
    .c_out_enable (c_out_enable),
    .ready        (ready)
  );

  bind ntm_content_based_addressing ntm_content_based_addressing_chk #(.I_MAX(I_MAX)) u_chk (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .busy         (busy),
    .c_out_enable (c_out_enable),
    .ready        (ready),
    .size_i_r     (size_i_r)
  );

  // 100 ns period
  always #50 CLK = ~CLK;

  //////////////////////////////
  // Checks and failure exits
  //////////////////////////////

  task automatic stop_with_failure();
    $display("Verification failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
      stop_with_failure();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t ns while waiting for %s", $time, what);
    stop_with_failure();
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic int floor_sqrt(input int v);
    int r;
    r = 0;
    while ((r + 1) * (r + 1) <= v)
      r++;
    return r;
  endfunction

  // Q1.8 cosine of the key against one row
  function automatic int model_cosine(input int row, input int n_j);
    int dot;
    int kk;
    int mm;
    int den;
    int q;
    dot = 0;
    kk  = 0;
    mm  = 0;
    for (int j = 0; j < n_j; j++) begin
      dot += key_v[j] * mem_v[row][j];
      kk  += key_v[j] * key_v[j];
      mm  += mem_v[row][j] * mem_v[row][j];
    end
    den = floor_sqrt(kk) * floor_sqrt(mm);
    // Zero norm on either side
    if (den == 0)
      return 0;
    q = (dot * 256) / den;
    if (q > 256)
      q = 256;
    else if (q < -256)
      q = -256;
    return q;
  endfunction

  // Base 2, beta in Q4.4
  function automatic logic [63:0] model_exponent(input int cosv, input int b);
    int x;
    int n;
    int f;
    x = (cosv * b) >>> 4;
    n = x >>> 8;
    f = x & 255;
    return 64'(256 + f) << (n + 16);
  endfunction

  task automatic build_expected(input int n_i, input int n_j, input int b);
    logic [63:0] e [I_MAX];
    logic [63:0] sum;
    sum = '0;
    for (int i = 0; i < n_i; i++) begin
      e[i] = model_exponent(model_cosine(i, n_j), b);
      sum  = sum + e[i];
    end
    for (int i = 0; i < n_i; i++)
      exp_w[i] = (e[i] << 16) / sum;
  endtask

  //////////////////////////////
  // Stimulus and response
  //////////////////////////////

  task automatic fill_random(input int n_i, input int n_j);
    logic signed [7:0] r8;
    for (int j = 0; j < n_j; j++) begin
      r8 = $random(seed);
      key_v[j] = r8;
    end
    for (int i = 0; i < n_i; i++) begin
      for (int j = 0; j < n_j; j++) begin
        r8 = $random(seed);
        mem_v[i][j] = r8;
      end
    end
  endtask

  // Start, key, then rows row-major; optional idle gaps between row elements
  task automatic drive_run(input int n_i, input int n_j, input int b,
                           input bit gaps, input bit mid_start);
    int idle;
    @(posedge CLK);
    start  <= 1'b1;
    size_i <= n_i[$clog2(I_MAX+1)-1:0];
    size_j <= n_j[$clog2(J_MAX+1)-1:0];
    beta   <= b[7:0];
    @(posedge CLK);
    start <= 1'b0;
    for (int j = 0; j < n_j; j++) begin
      k_in        <= key_v[j][7:0];
      k_in_enable <= 1'b1;
      @(posedge CLK);
    end
    k_in_enable <= 1'b0;
    for (int i = 0; i < n_i; i++) begin
      for (int j = 0; j < n_j; j++) begin
        if (gaps) begin
          idle = $unsigned($random(seed)) % 3;
          m_in_enable <= 1'b0;
          repeat (idle) @(posedge CLK);
        end
        // Start while busy, other sizes, must change nothing
        if (mid_start && i == 0 && j == 0) begin
          start  <= 1'b1;
          size_i <= 1;
          size_j <= 1;
          beta   <= 8'hff;
        end else begin
          start <= 1'b0;
        end
        m_in        <= mem_v[i][j][7:0];
        m_in_enable <= 1'b1;
        @(posedge CLK);
      end
    end
    start       <= 1'b0;
    m_in_enable <= 1'b0;
  endtask

  // Weights in index order, then ready one cycle after the last
  task automatic collect_weights(input int n_i);
    int cyc;
    for (int i = 0; i < n_i; i++) begin
      cyc = 0;
      @(negedge CLK);
      while (c_out_enable !== 1'b1) begin
        check_value("ready before last weight", ready, 0);
        cyc++;
        if (cyc > WAIT_LIMIT)
          report_timeout("c_out_enable");
        @(negedge CLK);
      end
      check_value($sformatf("weight %0d", i), c_out, exp_w[i]);
    end
    cyc = 0;
    @(negedge CLK);
    while (ready !== 1'b1) begin
      cyc++;
      if (cyc > WAIT_LIMIT)
        report_timeout("ready");
      @(negedge CLK);
    end
    check_value("cycles from last weight to ready", cyc, 0);
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge CLK);
      check_value("c_out_enable", c_out_enable, 0);
      check_value("ready", ready, 0);
    end
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_reset_quiet();
    expect_quiet(20);
  endtask

  task automatic test_single_row();
    fill_random(1, 7);
    exp_w[0] = 64'd65536;
    drive_run(1, 7, 8'h30, 1'b0, 1'b0);
    collect_weights(1);
  endtask

  task automatic test_equal_weights();
    // Identical rows
    fill_random(5, 6);
    for (int i = 1; i < 5; i++) begin
      for (int j = 0; j < 6; j++)
        mem_v[i][j] = mem_v[0][j];
    end
    for (int i = 0; i < 5; i++)
      exp_w[i] = 65536 / 5;
    drive_run(5, 6, 8'h58, 1'b1, 1'b0);
    collect_weights(5);
    // Zero key, random rows
    fill_random(3, 9);
    for (int j = 0; j < 9; j++)
      key_v[j] = 0;
    for (int i = 0; i < 3; i++)
      exp_w[i] = 65536 / 3;
    drive_run(3, 9, 8'hf0, 1'b0, 1'b0);
    collect_weights(3);
  endtask

  task automatic test_random_runs();
    int n_i;
    int n_j;
    int b;
    for (int n = 0; n < 8; n++) begin
      n_i = 1 + $unsigned($random(seed)) % I_MAX;
      n_j = 1 + $unsigned($random(seed)) % J_MAX;
      b   = $unsigned($random(seed)) % 256;
      fill_random(n_i, n_j);
      build_expected(n_i, n_j, b);
      drive_run(n_i, n_j, b, (n % 2) == 1, 1'b0);
      collect_weights(n_i);
    end
  endtask

  task automatic test_zero_row();
    fill_random(4, 8);
    key_v[0] = 5;
    for (int j = 0; j < 8; j++)
      mem_v[2][j] = 0;
    build_expected(4, 8, 8'h6a);
    drive_run(4, 8, 8'h6a, 1'b1, 1'b0);
    collect_weights(4);
  endtask

  task automatic test_back_to_back();
    fill_random(3, 5);
    build_expected(3, 5, 8'h44);
    drive_run(3, 5, 8'h44, 1'b0, 1'b1);
    collect_weights(3);
    // Single ready pulse, nothing trailing
    expect_quiet(4);
    fill_random(6, 2);
    build_expected(6, 2, 8'h9c);
    drive_run(6, 2, 8'h9c, 1'b1, 1'b0);
    collect_weights(6);
    expect_quiet(100);
  endtask

  initial begin
    seed        = 1;
    CLK         = 1'b0;
    RST         = 1'b1;
    start       = 1'b0;
    size_i      = '0;
    size_j      = '0;
    beta        = '0;
    k_in        = '0;
    k_in_enable = 1'b0;
    m_in        = '0;
    m_in_enable = 1'b0;
    repeat (10) @(posedge CLK);
    RST <= 1'b0;

    test_reset_quiet();
    test_single_row();
    test_equal_weights();
    test_random_runs();
    test_zero_row();
    test_back_to_back();

    @(negedge CLK);
    if (i_dut.u_chk.fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Protocol checker saw %0d assertion failures", i_dut.u_chk.fail_count);
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/ntm_pkg.sv
verilog/ntm_score_if.sv
verilog/ntm_divider.sv
verilog/ntm_integer_sqrt.sv
verilog/ntm_cosine_similarity.sv
verilog/ntm_vector_exponentiator.sv
verilog/ntm_vector_softmax.sv
verilog/ntm_content_based_addressing.sv
sim/ntm_content_based_addressing_chk.sv
sim/ntm_content_based_addressing_tb.sv

// ==== verilog/ntm_content_based_addressing.sv ====
//////////////////////////////
// Content-based addressing for an NTM memory,
// c[i] = softmax(beta * cos(k, M[i])), exact integer math.
// Strobe start with sizes and beta, then key, then rows;
// weights come out on c_out_enable, ready after the last one.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ntm_content_based_addressing #(
  parameter int I_MAX = 8,
  parameter int J_MAX = 16
) (
  input  wire                       CLK,
  input  wire                       RST,
  input  wire                       start,
  input  wire [$clog2(I_MAX+1)-1:0] size_i,
  input  wire [$clog2(J_MAX+1)-1:0] size_j,
  input  wire ntm_pkg::beta_t       beta,
  input  wire ntm_pkg::elem_t       k_in,
  input  wire                       k_in_enable,
  input  wire ntm_pkg::elem_t       m_in,
  input  wire                       m_in_enable,
  output ntm_pkg::prob_t            c_out,
  output logic                      c_out_enable,
  output logic                      ready
);

  import ntm_pkg::*;

  localparam int AW = $clog2(I_MAX);

  logic                       busy;
  logic                       run_start;
  logic                       sm_done;
  logic [$clog2(I_MAX+1)-1:0] size_i_r;
  logic [$clog2(J_MAX+1)-1:0] size_j_r;
  beta_t                      beta_r;

  ntm_score_if #(.WIDTH(COS_WIDTH), .IDX_WIDTH(AW)) cos_if ();
  ntm_score_if #(.WIDTH(EXP_WIDTH), .IDX_WIDTH(AW)) exp_if ();

  //////////////////////////////
  // Run controller
  //////////////////////////////

  // Start while busy is dropped
  assign run_start = start && !busy;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy  <= 1'b0;
      ready <= 1'b0;
    end else begin
      ready <= sm_done;
      if (run_start)
        busy <= 1'b1;
      else if (sm_done)
        busy <= 1'b0;
    end
  end

  // Sizes and beta held for the whole run
  always_ff @(posedge CLK) begin
    if (run_start) begin
      size_i_r <= size_i;
      size_j_r <= size_j;
      beta_r   <= beta;
    end
  end

  //////////////////////////////
  // Stages
  //////////////////////////////

  ntm_cosine_similarity #(.I_MAX(I_MAX), .J_MAX(J_MAX)) u_cosine (
    .CLK         (CLK),
    .RST         (RST),
    .start       (run_start),
    .size_i      (size_i_r),
    .size_j      (size_j_r),
    .k_in        (k_in),
    .k_in_enable (k_in_enable),
    .m_in        (m_in),
    .m_in_enable (m_in_enable),
    .cos_out     (cos_if)
  );

  ntm_vector_exponentiator #(.IDX_WIDTH(AW)) u_exp (
    .CLK     (CLK),
    .RST     (RST),
    .beta    (beta_r),
    .cos_in  (cos_if),
    .exp_out (exp_if)
  );

  ntm_vector_softmax #(.I_MAX(I_MAX)) u_softmax (
    .CLK          (CLK),
    .RST          (RST),
    .exp_in       (exp_if),
    .c_out        (c_out),
    .c_out_enable (c_out_enable),
    .done         (sm_done)
  );

endmodule

`default_nettype wire

// ==== verilog/ntm_cosine_similarity.sv ====
//////////////////////////////
// Cosine of the key against each memory row, Q1.8, clamped.
// Key first, then rows row-major; finished rows wait in a queue
// while a serial engine does sqrt and divide per row.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ntm_cosine_similarity #(
  parameter int I_MAX = 8,
  parameter int J_MAX = 16
) (
  input  wire                       CLK,
  input  wire                       RST,
  input  wire                       start,
  input  wire [$clog2(I_MAX+1)-1:0] size_i,
  input  wire [$clog2(J_MAX+1)-1:0] size_j,
  input  wire ntm_pkg::elem_t       k_in,
  input  wire                       k_in_enable,
  input  wire ntm_pkg::elem_t       m_in,
  input  wire                       m_in_enable,
  ntm_score_if.source               cos_out
);

  import ntm_pkg::*;

  localparam int IW   = $clog2(I_MAX + 1);
  localparam int JW   = $clog2(J_MAX + 1);
  localparam int AW   = $clog2(I_MAX);
  localparam int KAW  = $clog2(J_MAX);
  localparam int RTW  = DOT_WIDTH / 2;
  localparam int DIVW = DOT_WIDTH + 8;

  typedef enum logic [1:0] {E_IDLE, E_SQRT, E_DIV} eng_state_t;

  // Key store
  elem_t                          k_mem [J_MAX];
  logic [JW-1:0]                  k_cnt;
  logic [DOT_WIDTH-1:0]           k_sq;
  logic signed [2*ELEM_WIDTH-1:0] k_term;

  // Row accumulators
  logic [JW-1:0]                  j_cnt;
  logic signed [DOT_WIDTH-1:0]    dot_acc;
  logic [DOT_WIDTH-1:0]           m_sq;
  logic signed [2*ELEM_WIDTH-1:0] dot_term;
  logic signed [2*ELEM_WIDTH-1:0] m_term;
  logic                           row_end;

  // Row queue, slot = row index
  logic signed [DOT_WIDTH-1:0]    q_dot [I_MAX];
  logic [DOT_WIDTH-1:0]           q_sq  [I_MAX];
  logic [IW-1:0]                  wr_cnt;
  logic [IW-1:0]                  rd_cnt;
  logic signed [DOT_WIDTH-1:0]    q_head;
  logic                           pending;

  // Engine
  eng_state_t                     state;
  logic                           neg;
  logic [DOT_WIDTH-1:0]           mag;
  logic                           sqrt_start;
  logic                           k_root_done;
  logic                           m_root_done;
  logic [RTW-1:0]                 k_root;
  logic [RTW-1:0]                 m_root;
  logic [DOT_WIDTH-1:0]           root_prod;
  logic                           div_start;
  logic                           div_done;
  logic [DIVW-1:0]                quo;
  logic [COS_WIDTH-1:0]           cos_mag;

  //////////////////////////////
  // Input side
  //////////////////////////////

  assign k_term   = k_in * k_in;
  assign m_term   = m_in * m_in;
  assign dot_term = k_mem[j_cnt[KAW-1:0]] * m_in;
  assign row_end  = m_in_enable && (j_cnt == size_j - 1'b1);

  // Element and row counters
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      k_cnt  <= '0;
      j_cnt  <= '0;
      wr_cnt <= '0;
    end else if (start) begin
      k_cnt  <= '0;
      j_cnt  <= '0;
      wr_cnt <= '0;
    end else begin
      if (k_in_enable)
        k_cnt <= k_cnt + 1'b1;
      if (row_end) begin
        j_cnt  <= '0;
        wr_cnt <= wr_cnt + 1'b1;
      end else if (m_in_enable) begin
        j_cnt <= j_cnt + 1'b1;
      end
    end
  end

  // Key norm, dot product, row norm
  always_ff @(posedge CLK) begin
    if (start) begin
      k_sq    <= '0;
      dot_acc <= '0;
      m_sq    <= '0;
    end else begin
      if (k_in_enable) begin
        k_mem[k_cnt[KAW-1:0]] <= k_in;
        k_sq <= k_sq + DOT_WIDTH'(k_term);
      end
      if (row_end) begin
        // Push finished row, restart sums
        q_dot[wr_cnt[AW-1:0]] <= dot_acc + dot_term;
        q_sq[wr_cnt[AW-1:0]]  <= m_sq + DOT_WIDTH'(m_term);
        dot_acc <= '0;
        m_sq    <= '0;
      end else if (m_in_enable) begin
        dot_acc <= dot_acc + dot_term;
        m_sq    <= m_sq + DOT_WIDTH'(m_term);
      end
    end
  end

  //////////////////////////////
  // Engine
  //////////////////////////////

  assign q_head     = q_dot[rd_cnt[AW-1:0]];
  assign pending    = rd_cnt != wr_cnt;
  assign sqrt_start = (state == E_IDLE) && pending;
  assign div_start  = (state == E_SQRT) && k_root_done && m_root_done;
  assign root_prod  = k_root * m_root;
  // Floor roots can push the ratio above one
  assign cos_mag    = (quo > DIVW'(COS_ONE)) ? COS_WIDTH'(COS_ONE) : quo[COS_WIDTH-1:0];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state          <= E_IDLE;
      rd_cnt         <= '0;
      cos_out.enable <= 1'b0;
    end else begin
      cos_out.enable <= 1'b0;
      case (state)
        E_IDLE: if (pending) state <= E_SQRT;
        E_SQRT: if (div_start) state <= E_DIV;
        E_DIV: begin
          if (div_done) begin
            state          <= E_IDLE;
            rd_cnt         <= rd_cnt + 1'b1;
            cos_out.enable <= 1'b1;
          end
        end
        default: state <= E_IDLE;
      endcase
      if (start)
        rd_cnt <= '0;
    end
  end

  // Divide magnitude, sign applied after
  always_ff @(posedge CLK) begin
    if (sqrt_start) begin
      neg <= q_head < 0;
      mag <= (q_head < 0) ? DOT_WIDTH'(-q_head) : DOT_WIDTH'(q_head);
    end
    if (div_done) begin
      cos_out.score <= neg ? -cos_mag : cos_mag;
      cos_out.index <= rd_cnt[AW-1:0];
      cos_out.last  <= rd_cnt == size_i - 1'b1;
    end
  end

  ntm_integer_sqrt #(.WIDTH(DOT_WIDTH)) u_k_sqrt (
    .CLK      (CLK),
    .RST      (RST),
    .start    (sqrt_start),
    .radicand (k_sq),
    .root     (k_root),
    .done     (k_root_done)
  );

  ntm_integer_sqrt #(.WIDTH(DOT_WIDTH)) u_m_sqrt (
    .CLK      (CLK),
    .RST      (RST),
    .start    (sqrt_start),
    .radicand (q_sq[rd_cnt[AW-1:0]]),
    .root     (m_root),
    .done     (m_root_done)
  );

  // Zero norm gives zero divisor, hence zero cosine
  ntm_divider #(.WIDTH(DIVW)) u_div (
    .CLK      (CLK),
    .RST      (RST),
    .start    (div_start),
    .dividend ({mag, 8'b0}),
    .divisor  (DIVW'(root_prod)),
    .quotient (quo),
    .done     (div_done)
  );

endmodule

`default_nettype wire

// ==== verilog/ntm_divider.sv ====
//////////////////////////////
// Serial restoring unsigned divider, one quotient bit per cycle.
// Pulse start with the operands, done comes WIDTH+1 cycles later.
// Zero divisor returns a zero quotient.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ntm_divider #(
  parameter int WIDTH = 32
) (
  input  wire               CLK,
  input  wire               RST,
  input  wire               start,
  input  wire [WIDTH-1:0]   dividend,
  input  wire [WIDTH-1:0]   divisor,
  output logic [WIDTH-1:0]  quotient,
  output logic              done
);

  localparam int CW = $clog2(WIDTH + 1);

  logic [WIDTH-1:0] rem;
  logic [WIDTH-1:0] quo;
  logic [WIDTH-1:0] div_r;
  logic [WIDTH:0]   trial;
  logic             fits;
  logic [CW-1:0]    cnt;
  logic             busy;

  // Partial remainder with next dividend bit shifted in
  assign trial = {rem, quo[WIDTH-1]};
  assign fits  = trial >= {1'b0, div_r};

  // Iteration counter
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy <= 1'b0;
      cnt  <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        cnt  <= CW'(WIDTH);
      end else if (busy) begin
        if (cnt != '0) begin
          cnt <= cnt - 1'b1;
        end else begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if (start) begin
      rem   <= '0;
      quo   <= dividend;
      div_r <= divisor;
    end else if (busy && cnt != '0) begin
      // Subtract only when it fits, quotient bit enters from the right
      rem <= fits ? WIDTH'(trial - {1'b0, div_r}) : trial[WIDTH-1:0];
      quo <= {quo[WIDTH-2:0], fits};
    end else if (busy) begin
      quotient <= (div_r == '0) ? '0 : quo;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ntm_integer_sqrt.sv ====
//////////////////////////////
// Serial floor square root, two radicand bits per cycle.
// Pulse start with the radicand, done comes WIDTH/2+1 cycles later.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ntm_integer_sqrt #(
  parameter int WIDTH = 24
) (
  input  wire                 CLK,
  input  wire                 RST,
  input  wire                 start,
  input  wire [WIDTH-1:0]     radicand,
  output logic [WIDTH/2-1:0]  root,
  output logic                done
);

  localparam int RW = WIDTH / 2;
  localparam int CW = $clog2(RW + 1);

  logic [WIDTH-1:0] rad;
  logic [RW+1:0]    rem;
  logic [RW-1:0]    acc;
  logic [RW+1:0]    pair;
  logic [RW+1:0]    trial;
  logic             fits;
  logic [CW-1:0]    cnt;
  logic             busy;

  // Remainder times four plus next bit pair, against 4*root+1
  assign pair  = {rem[RW-1:0], rad[WIDTH-1 -: 2]};
  assign trial = {acc, 2'b01};
  assign fits  = pair >= trial;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy <= 1'b0;
      cnt  <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        cnt  <= CW'(RW);
      end else if (busy) begin
        if (cnt != '0) begin
          cnt <= cnt - 1'b1;
        end else begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // One root digit per step
  always_ff @(posedge CLK) begin
    if (start) begin
      rad <= radicand;
      rem <= '0;
      acc <= '0;
    end else if (busy && cnt != '0) begin
      rad <= rad << 2;
      rem <= fits ? pair - trial : pair;
      acc <= {acc[RW-2:0], fits};
    end else if (busy) begin
      root <= acc;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ntm_pkg.sv ====
//////////////////////////////
// Shared widths, fixed-point constants and element types of the
// content-based addressing unit. Stage modules import it.
//////////////////////////////
`default_nettype none

package ntm_pkg;

  // Key and memory elements, signed integers
  localparam int ELEM_WIDTH = 8;
  typedef logic signed [ELEM_WIDTH-1:0] elem_t;

  // Dot product and squared norm accumulators
  localparam int DOT_WIDTH = 24;

  // Cosine in signed Q1.8
  localparam int COS_WIDTH = 10;
  typedef logic signed [COS_WIDTH-1:0] cos_t;
  // Clamp limit, 1.0 in Q1.8
  localparam int COS_ONE = 256;

  // Key strength, unsigned Q4.4
  localparam int BETA_WIDTH = 8;
  typedef logic [BETA_WIDTH-1:0] beta_t;

  // Base-2 exponent result
  localparam int EXP_WIDTH = 42;
  typedef logic [EXP_WIDTH-1:0] exp_t;
  // Shift bias, keeps n + bias non-negative
  localparam int EXP_OFFSET = 16;

  // Output weight, 16 fraction bits
  localparam int PROB_WIDTH = 17;
  typedef logic [PROB_WIDTH-1:0] prob_t;

endpackage

`default_nettype wire

// ==== verilog/ntm_score_if.sv ====
//////////////////////////////
// Indexed score stream between pipeline stages.
// One enable strobe per row, last marks the final row.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

interface ntm_score_if #(
  parameter int WIDTH     = 10,
  parameter int IDX_WIDTH = 3
);

  // Payload, valid while enable is high
  logic [WIDTH-1:0]     score;
  logic [IDX_WIDTH-1:0] index;
  logic                 last;

  // Single-cycle strobe, no back-pressure
  logic                 enable;

  modport source (output score, output enable, output index, output last);
  modport sink   (input score, input enable, input index, input last);

endinterface

`default_nettype wire

// ==== verilog/ntm_vector_exponentiator.sv ====
//////////////////////////////
// Scales each cosine by beta and forms the base-2 exponent
// (256 + f) << (n + 16). Fixed two-cycle latency.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ntm_vector_exponentiator #(
  parameter int IDX_WIDTH = 3
) (
  input  wire             CLK,
  input  wire             RST,
  input  wire ntm_pkg::beta_t beta,
  ntm_score_if.sink       cos_in,
  ntm_score_if.source     exp_out
);

  import ntm_pkg::*;

  localparam int PW = COS_WIDTH + BETA_WIDTH + 1;
  localparam int XW = PW - 4;

  cos_t                  cos_val;
  logic signed [PW-1:0]  prod;
  logic signed [XW-1:0]  x_r;
  logic signed [XW-9:0]  n_int;
  logic [7:0]            frac;
  logic [5:0]            shamt;
  logic                  s1_en;
  logic                  s1_last;
  logic [IDX_WIDTH-1:0]  s1_index;

  // Q1.8 times Q4.4, beta kept non-negative
  assign cos_val = cos_t'(cos_in.score);
  assign prod    = cos_val * $signed({1'b0, beta});

  // Integer and fraction parts of x
  assign n_int = x_r[XW-1:8];
  assign frac  = x_r[7:0];
  assign shamt = 6'(n_int + EXP_OFFSET);

  // Stage valids
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_en          <= 1'b0;
      exp_out.enable <= 1'b0;
    end else begin
      s1_en          <= cos_in.enable;
      exp_out.enable <= s1_en;
    end
  end

  always_ff @(posedge CLK) begin
    // Stage 1, drop four fraction bits
    x_r      <= XW'(prod >>> 4);
    s1_index <= cos_in.index;
    s1_last  <= cos_in.last;
    // Stage 2, {1, f} is 256 + f
    exp_out.score <= EXP_WIDTH'({1'b1, frac}) << shamt;
    exp_out.index <= s1_index;
    exp_out.last  <= s1_last;
  end

endmodule

`default_nettype wire

// ==== verilog/ntm_vector_softmax.sv ====
//////////////////////////////
// Buffers exponents and sums them; after last, divides each
// entry (shifted by 16) by the sum in index order.
// done pulses together with the final weight.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ntm_vector_softmax #(
  parameter int I_MAX = 8
) (
  input  wire             CLK,
  input  wire             RST,
  ntm_score_if.sink       exp_in,
  output ntm_pkg::prob_t  c_out,
  output logic            c_out_enable,
  output logic            done
);

  import ntm_pkg::*;

  localparam int AW   = $clog2(I_MAX);
  localparam int SUMW = EXP_WIDTH + AW;
  localparam int DIVW = SUMW + 16;

  typedef enum logic [1:0] {S_COLLECT, S_START, S_WAIT} sm_state_t;

  sm_state_t        state;
  exp_t             e_mem [I_MAX];
  logic [SUMW-1:0]  sum;
  logic [AW-1:0]    rd_idx;
  logic [AW-1:0]    last_idx;
  logic             div_start;
  logic             div_done;
  logic [DIVW-1:0]  quo;

  assign div_start = state == S_START;

  // Exponent buffer
  always_ff @(posedge CLK) begin
    if (exp_in.enable)
      e_mem[exp_in.index] <= exp_in.score;
  end

  //////////////////////////////
  // Sum, then one division per row
  //////////////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= S_COLLECT;
      sum          <= '0;
      rd_idx       <= '0;
      last_idx     <= '0;
      c_out_enable <= 1'b0;
      done         <= 1'b0;
    end else begin
      c_out_enable <= 1'b0;
      done         <= 1'b0;
      case (state)
        S_COLLECT: begin
          if (exp_in.enable) begin
            sum <= sum + SUMW'(exp_in.score);
            if (exp_in.last) begin
              last_idx <= exp_in.index;
              rd_idx   <= '0;
              state    <= S_START;
            end
          end
        end
        S_START: state <= S_WAIT;
        S_WAIT: begin
          if (div_done) begin
            c_out_enable <= 1'b1;
            if (rd_idx == last_idx) begin
              // Run complete, clear sum for the next one
              done  <= 1'b1;
              sum   <= '0;
              state <= S_COLLECT;
            end else begin
              rd_idx <= rd_idx + 1'b1;
              state  <= S_START;
            end
          end
        end
        default: state <= S_COLLECT;
      endcase
    end
  end

  // Weight never exceeds 1.0, fits 17 bits
  always_ff @(posedge CLK) begin
    if (div_done)
      c_out <= quo[PROB_WIDTH-1:0];
  end

  ntm_divider #(.WIDTH(DIVW)) u_div (
    .CLK      (CLK),
    .RST      (RST),
    .start    (div_start),
    .dividend (DIVW'({e_mem[rd_idx], 16'b0})),
    .divisor  (DIVW'(sum)),
    .quotient (quo),
    .done     (div_done)
  );

endmodule

`default_nettype wire
